//--- list.f
+incdir+hw
hw/fetch_pkg.sv
hw/fetch_if.sv
hw/fetchbuffer_data.sv
hw/fetchbuffer_ctrl.sv
hw/fetchbuffer.sv
testbench/fetchbuffer_checker.sv
testbench/fetchbuffer_tb.sv

//--- testbench/fetchbuffer_tb.sv
`timescale 1ns/100ps

module fetchbuffer_tb;

  localparam int num_requests = 300;
  localparam int reset_cycles = 8;
  localparam int watchdog_cycles = num_requests * 40 + reset_cycles + 8;

  logic clock;
  logic reset;
  logic req_valid;
  logic req_fence;
  logic req_spec;
  logic [31:0] req_addr;
  logic resp_ready;
  logic [31:0] resp_data;
  logic resp_error;
  logic imem_valid;
  logic [31:0] imem_addr;
  logic imem_ready;
  logic [31:0] imem_rdata;
  logic imem_error;

  int responses = 0;
  int error_responses = 0;
  int flushes = 0;
  int tb_errors = 0;

  fetchbuffer UUT (.*);

  bind fetchbuffer fetchbuffer_checker checker_inst (.*);

  // halfword h holds h[13:0] and two code bits
  function automatic logic [15:0] half_value(input logic [31:0] h);
    return {h[13:0], (h % 3 != 0) ? 2'b11 : 2'b01};
  endfunction

  function automatic logic [31:0] word_value(input logic [31:0] addr);
    return {half_value({addr[31:2], 1'b1}), half_value({addr[31:2], 1'b0})};
  endfunction

  function automatic int step_for(input logic [31:0] addr);
    logic [15:0] first;
    first = half_value({1'b0, addr[31:1]});
    return (first[1:0] == 2'b11) ? 4 : 2;
  endfunction

  initial begin
    clock = 1'b0;
    forever #50 clock = ~clock;
  end

  // memory with one reply in flight at most
  initial begin
    imem_ready = 1'b0;
    imem_rdata = '0;
    imem_error = 1'b0;
    forever begin
      @(posedge clock);
      if (!reset) begin
        imem_ready <= 1'b0;
      end else if (imem_valid && !imem_ready) begin
        imem_ready <= 1'b1;
        imem_rdata <= word_value(imem_addr);
        imem_error <= imem_addr >= 32'h0000_F000;
      end else begin
        imem_ready <= 1'b0;
      end
    end
  end

  initial begin
    #(watchdog_cycles * 100);
    $display("timeout: the DUT stopped answering requests");
    $display("Simulation FAILED");
    $finish;
  end

  initial begin
    logic [31:0] addr;
    logic jump;
    logic fence_pick;
    int total;
    void'($urandom(4));
    reset = 1'b0;
    req_valid = 1'b0;
    req_fence = 1'b0;
    req_spec = 1'b0;
    req_addr = '0;
    repeat (reset_cycles) @(posedge clock);
    reset <= 1'b1;
    repeat (3) @(posedge clock);
    addr = '0;
    for (int n = 0; n < num_requests; n++) begin
      jump = n > 0 && ($urandom % 8 == 0);
      if (jump) begin
        flushes++;
        if (flushes % 4 == 0) begin
          addr = 32'h0000_F000 + ($urandom % 32'h1000);   // error region
        end else begin
          addr = $urandom % 32'h1_0000;
        end
        addr[0] = 1'b0;
      end
      fence_pick = jump && ($urandom % 2 == 0);
      req_valid <= 1'b1;
      req_addr <= addr;
      req_fence <= fence_pick;
      req_spec <= jump && !fence_pick;
      do @(posedge clock); while (!resp_ready);
      responses++;
      if (resp_error) error_responses++;
      addr = addr + step_for(addr);
    end
    req_valid <= 1'b0;
    req_fence <= 1'b0;
    req_spec <= 1'b0;
    repeat (4) @(posedge clock);
    if (error_responses == 0) begin
      tb_errors++;
      $display("no response came from the memory error region");
    end
    total = UUT.checker_inst.fail_count + tb_errors;
    $display("errors: %0d assertion failures, %0d testbench errors, %0d responses",
             UUT.checker_inst.fail_count, tb_errors, responses);
    if (total == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

//--- testbench/fetchbuffer_checker.sv
`timescale 1ns/100ps

module fetchbuffer_checker (
  input logic clock,
  input logic reset,
  input logic req_valid,
  input logic req_fence,
  input logic req_spec,
  input logic [31:0] req_addr,
  input logic resp_ready,
  input logic [31:0] resp_data,
  input logic resp_error,
  input logic imem_valid,
  input logic imem_ready
);
  import fetch_pkg::*;

  int fail_count = 0;
  logic req_open;      // request already seen in an earlier cycle
  logic halted;
  logic flush_start;

  function automatic logic [15:0] model_half(input logic [31:0] h);
    return {h[13:0], (h % 3 != 0) ? 2'b11 : 2'b01};
  endfunction

  function automatic fetch_word_u model_word(input logic [31:0] addr);
    fetch_word_u w;
    w.half.lower = model_half({addr[31:2], 1'b0});
    w.half.upper = model_half({addr[31:2], 1'b1});
    return w;
  endfunction

  function automatic logic [31:0] aligned_result(input logic [31:0] addr);
    fetch_word_u w;
    w = model_word(addr);
    return (w.half.lower[1:0] == 2'b11) ? w.full : {16'h0, w.half.lower};
  endfunction

  function automatic logic [31:0] upper_result(input logic [31:0] addr);
    fetch_word_u w;
    fetch_word_u next;
    w = model_word(addr);
    next = model_word(addr + 32'd4);
    return (w.half.upper[1:0] == 2'b11) ? {next.half.lower, w.half.upper}
                                        : {16'h0, w.half.upper};
  endfunction

  // error of the last word the instruction touches
  function automatic logic error_result(input logic [31:0] addr);
    fetch_word_u w;
    logic [31:0] last;
    w = model_word(addr);
    last = (addr[1] && w.half.upper[1:0] == 2'b11) ? addr + 32'd4 : addr;
    return {last[31:2], 2'b00} >= 32'h0000_F000;
  endfunction

  assign flush_start = req_valid && (req_fence || req_spec) && !req_open;

  always_ff @(posedge clock) begin
    if (!reset) begin
      req_open <= 1'b0;
      halted <= 1'b0;
    end else begin
      req_open <= req_valid && !resp_ready;
      if (imem_ready) begin
        halted <= 1'b0;   // halt ends on the first reply
      end else if (flush_start) begin
        halted <= 1'b1;
      end
    end
  end

  idle_after_reset: assert property (@(posedge clock) $rose(reset) |-> !imem_valid)
    else begin
      fail_count++;
      $error("imem_valid was high in the idle cycle after reset");
    end

  no_response_without_request: assert property (@(posedge clock) disable iff (!reset)
    !req_valid |-> !resp_ready)
    else begin
      fail_count++;
      $error("resp_ready was high with no request pending");
    end

  aligned_data: assert property (@(posedge clock) disable iff (!reset)
    resp_ready && !req_addr[1] |-> resp_data == aligned_result(req_addr))
    else begin
      fail_count++;
      $error("mismatch resp_data at %h: got %h, expected %h", $sampled(req_addr),
             $sampled(resp_data), aligned_result($sampled(req_addr)));
    end

  upper_data: assert property (@(posedge clock) disable iff (!reset)
    resp_ready && req_addr[1] |-> resp_data == upper_result(req_addr))
    else begin
      fail_count++;
      $error("mismatch resp_data at %h: got %h, expected %h", $sampled(req_addr),
             $sampled(resp_data), upper_result($sampled(req_addr)));
    end

  error_bit: assert property (@(posedge clock) disable iff (!reset)
    resp_ready |-> resp_error == error_result(req_addr))
    else begin
      fail_count++;
      $error("mismatch resp_error at %h: got %h, expected %h", $sampled(req_addr),
             $sampled(resp_error), error_result($sampled(req_addr)));
    end

  flush_no_response: assert property (@(posedge clock) disable iff (!reset)
    flush_start |-> !resp_ready)
    else begin
      fail_count++;
      $error("resp_ready was high in the cycle of a flush");
    end

  halt_quiet: assert property (@(posedge clock) disable iff (!reset)
    halted |-> !imem_valid && !resp_ready)
    else begin
      fail_count++;
      $error("imem_valid or resp_ready was high while the buffer was halted");
    end

  reply_gap: assert property (@(posedge clock) disable iff (!reset)
    imem_ready |-> !imem_valid)
    else begin
      fail_count++;
      $error("imem_valid was high in a cycle with imem_ready");
    end

endmodule

//--- hw/fetchbuffer.sv
`timescale 1ns/100ps

module fetchbuffer (
  input logic clock,
  input logic reset,
  input logic req_valid,
  input logic req_fence,
  input logic req_spec,
  input logic [31:0] req_addr,
  output logic resp_ready,
  output logic [31:0] resp_data,
  output logic resp_error,
  output logic imem_valid,
  output logic [31:0] imem_addr,
  input logic imem_ready,
  input logic [31:0] imem_rdata,
  input logic imem_error
);

  buffer_if buffer_bus ();
  imem_if imem_bus ();

  // memory side to plain ports
  assign imem_valid = imem_bus.valid;
  assign imem_addr = imem_bus.addr;
  assign imem_bus.ready = imem_ready;
  assign imem_bus.rdata = imem_rdata;
  assign imem_bus.error = imem_error;

  fetchbuffer_data data_inst (
    .clock (clock),
    .bus   (buffer_bus.array)
  );

  fetchbuffer_ctrl ctrl_inst (
    .clock      (clock),
    .reset      (reset),
    .req_valid  (req_valid),
    .req_fence  (req_fence),
    .req_spec   (req_spec),
    .req_addr   (req_addr),
    .resp_ready (resp_ready),
    .resp_error (resp_error),
    .resp_data  (resp_data),
    .bus        (buffer_bus.ctrl),
    .imem       (imem_bus.ctrl)
  );

endmodule

//--- hw/fetchbuffer_ctrl.sv
`timescale 1ns/100ps
`include "fetch_defs.svh"

module fetchbuffer_ctrl (
  input logic clock,
  input logic reset,
  input logic req_valid,
  input logic req_fence,
  input logic req_spec,
  input logic [31:0] req_addr,
  output logic resp_ready,
  output logic resp_error,
  output logic [31:0] resp_data,
  buffer_if.ctrl bus,
  imem_if.ctrl imem
);
  import fetch_pkg::*;

  localparam int iw = `fb_index_w;
  localparam int cw = `fb_index_w + 2;   // halfword count width

  localparam logic [1:0] idle = 2'd0;
  localparam logic [1:0] active = 2'd1;
  localparam logic [1:0] fence = 2'd2;
  localparam logic [1:0] spec = 2'd3;

  logic [1:0] state_q;
  logic [1:0] state_d;
  logic [`fb_depth-1:0] valid_q;
  logic [`fb_depth-1:0] valid_d;
  logic [cw-1:0] count_q;
  logic [cw-1:0] count_d;
  logic [31:0] addr_q;   // prefetch address
  logic [31:0] addr_d;
  logic [31:0] paddr_q;  // latched request address
  logic req_seen_q;

  logic [31:0] addr1;
  logic [31:0] addr2;
  logic [iw-1:0] rid1;
  logic [iw-1:0] rid2;
  logic [iw-1:0] widx;
  logic flush;
  logic full;
  logic halt;
  logic wen;
  logic byp1;
  logic byp2;
  logic hit1;
  logic hit2;
  fb_entry_t wentry;
  fb_entry_t w1;
  fb_entry_t w2;
  logic [31:0] data;
  logic error;
  logic ready;
  logic [1:0] step;

  assign addr1 = req_valid ? req_addr : paddr_q;
  assign addr2 = {addr1[31:2] + 30'd1, 2'b00};
  assign rid1 = addr1[iw+1:2];
  assign rid2 = addr2[iw+1:2];
  assign widx = addr_q[iw+1:2];

  // only the first cycle of a request can flush
  assign flush = req_valid && (req_fence || req_spec) && !req_seen_q && state_q == active;
  assign full = count_q >= fb_limit;

  assign wentry = '{error: imem.error, tag: addr_q[31:2], word: imem.rdata};

  always_comb begin
    state_d = state_q;
    valid_d = valid_q;
    count_d = count_q;
    addr_d = addr_q;
    halt = 1'b0;
    wen = 1'b0;
    ready = 1'b0;
    error = 1'b0;
    data = '0;
    step = 2'd0;

    case (state_q)
      idle: begin
        state_d = active;
      end
      active: begin
        if (flush) begin
          state_d = req_fence ? fence : spec;
          valid_d = '0;
          count_d = '0;
        end
      end
      default: begin
        halt = 1'b1;
      end
    endcase

    if (imem.ready && state_d == active) begin
      wen = 1'b1;
      valid_d[widx] = 1'b1;
      addr_d = addr_q + 32'd4;
      count_d = count_d + cw'(2);   // one word is two halfwords
    end

    // a reply in halt is dropped and prefetch restarts
    if ((imem.ready || full) && (state_d == fence || state_d == spec)) begin
      state_d = active;
      halt = 1'b0;
      addr_d = {addr1[31:2], 2'b00};
    end

    byp1 = wen && wentry.tag == addr1[31:2];
    byp2 = wen && wentry.tag == addr2[31:2];
    hit1 = byp1 || (valid_d[rid1] && bus.rdata1.tag == addr1[31:2]);
    hit2 = byp2 || (valid_d[rid2] && bus.rdata2.tag == addr2[31:2]);
    w1 = byp1 ? wentry : bus.rdata1;
    w2 = byp2 ? wentry : bus.rdata2;

    if (req_valid && !halt && hit1) begin
      if (!addr1[1]) begin
        data = w1.word.full;
        error = w1.error;
        ready = 1'b1;
      end else begin
        data[15:0] = w1.word.half.upper;
        error = w1.error;
        ready = data[1:0] != 2'b11 || hit2;   // full one needs the next word
        if (data[1:0] == 2'b11) begin
          data[31:16] = w2.word.half.lower;
          error = w2.error;
        end
      end
    end

    if (data[1:0] != 2'b11) begin
      data[31:16] = '0;   // compressed
    end

    if (ready) begin
      step = (data[1:0] == 2'b11) ? 2'd2 : 2'd1;
      if (cw'(step) <= count_d) begin
        count_d = count_d - cw'(step);
      end
    end
  end

  assign bus.wen = wen;
  assign bus.waddr = widx;
  assign bus.wdata = wentry;
  assign bus.raddr1 = rid1;
  assign bus.raddr2 = rid2;

  // a reply cycle never carries a new request
  assign imem.valid = state_q != idle && !halt && count_d < fb_limit && !imem.ready;
  assign imem.addr = addr_d;

  assign resp_ready = ready;
  assign resp_data = data;
  assign resp_error = error;

  always_ff @(posedge clock) begin
    if (!reset) begin
      state_q <= idle;
      valid_q <= '0;
      count_q <= '0;
      addr_q <= '0;
      req_seen_q <= 1'b0;
    end else begin
      state_q <= state_d;
      valid_q <= valid_d;
      count_q <= count_d;
      addr_q <= addr_d;
      req_seen_q <= req_valid && !ready && state_q != idle;
    end
  end

  always_ff @(posedge clock) begin
    if (req_valid) begin
      paddr_q <= req_addr;
    end
  end

endmodule

//--- hw/fetchbuffer_data.sv
`timescale 1ns/100ps
`include "fetch_defs.svh"

module fetchbuffer_data (
  input logic clock,
  buffer_if.array bus
);
  import fetch_pkg::*;

  fb_entry_t entries [0:`fb_depth-1];

  always_ff @(posedge clock) begin
    if (bus.wen) begin
      entries[bus.waddr] <= bus.wdata;
    end
  end

  // two independent read ports
  assign bus.rdata1 = entries[bus.raddr1];
  assign bus.rdata2 = entries[bus.raddr2];

endmodule

//--- hw/fetch_if.sv
`timescale 1ns/100ps
`include "fetch_defs.svh"

interface buffer_if #(
  parameter type entry_t = fetch_pkg::fb_entry_t
) ();

  logic wen;
  logic [`fb_index_w-1:0] waddr;
  entry_t wdata;
  logic [`fb_index_w-1:0] raddr1;
  logic [`fb_index_w-1:0] raddr2;
  entry_t rdata1;   // word at the request address
  entry_t rdata2;   // following word

  modport ctrl (
    output wen, waddr, wdata, raddr1, raddr2,
    input rdata1, rdata2
  );

  modport array (
    input wen, waddr, wdata, raddr1, raddr2,
    output rdata1, rdata2
  );

endinterface

interface imem_if ();
  import fetch_pkg::*;

  logic valid;
  logic [`fb_addr_w-1:0] addr;
  logic ready;   // one cycle after the address is taken
  fetch_word_u rdata;
  logic error;

  modport ctrl (
    output valid, addr,
    input ready, rdata, error
  );

  modport port (
    input valid, addr,
    output ready, rdata, error
  );

endinterface

//--- hw/fetch_pkg.sv
`include "fetch_defs.svh"

package fetch_pkg;

  localparam int fb_tag_w = `fb_addr_w - 2;      // word address bits
  localparam int fb_limit = 2 * `fb_depth - 2;   // full mark in halfwords

  // one fetched word, whole or as two halfwords
  typedef union packed {
    logic [31:0] full;
    struct packed {
      logic [15:0] upper;
      logic [15:0] lower;
    } half;
  } fetch_word_u;

  typedef struct packed {
    logic error;
    logic [fb_tag_w-1:0] tag;
    fetch_word_u word;
  } fb_entry_t;

endpackage

//--- hw/fetch_defs.svh
`ifndef FETCH_DEFS_SVH
`define FETCH_DEFS_SVH

// buffer entries, power of two
`define fb_depth 8

// entry index width
`define fb_index_w $clog2(`fb_depth)

// byte address width
`define fb_addr_w 32

`endif
